//--- verilog/l2_dir_pkg.sv
`default_nettype none

package l2_dir_pkg;

    // ============================================================
    // Directory geometry
    // ============================================================

    localparam int DEF_WAYS = 4;        // Default associativity
    localparam int DEF_SETS = 16;       // Default set count, must be a power of two

    // Width of a line address on wb_adr
    // The set index sits in the low bits and the tag takes the rest
    localparam int LINE_ADDR_BITS = 16;

    // ============================================================
    // Coherence state of one way
    // ============================================================

    typedef enum logic [1:0] {
        ST_INVALID   = 2'd0,    // Way holds no line and counts as empty
        ST_SHARED    = 2'd1,
        ST_EXCLUSIVE = 2'd2,
        ST_MODIFIED  = 2'd3
    } line_state_t;

endpackage

`default_nettype wire

//--- verilog/l2_wb_pkg.sv
`default_nettype none

package l2_wb_pkg;

    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_FILL   = 2'd1,
        OP_INVAL  = 2'd2
    } dir_op_t;

    localparam int WB_DATA_BITS = 8;

    // Request word on wb_dat_i, write cycles only
    localparam int REQ_OP_LSB    = 0;   // Opcode in bits 1:0
    localparam int REQ_STATE_LSB = 2;   // Fill state in bits 3:2

    // Response word on wb_dat_o
    // The way field holds the hit way, or the lowest empty way on a miss
    localparam int RSP_HIT_BIT    = 0;
    localparam int RSP_EMPTY_BIT  = 1;
    localparam int RSP_WAY_LSB    = 2;
    localparam int RSP_STATE_LSB  = 4;
    localparam int RSP_WR_WAY_LSB = 6;  // Way written, zero when nothing was written

endpackage

`default_nettype wire

//--- verilog/l2_req_decode.sv
`default_nettype none

module l2_req_decode #(
    parameter int SETS = l2_dir_pkg::DEF_SETS
) (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire                                        wb_cyc,
    input  wire                                        wb_stb,
    input  wire                                        wb_we,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-1:0]       wb_adr,
    input  wire [l2_wb_pkg::WB_DATA_BITS-1:0]          wb_dat_i,
    input  wire                                        done,
    output logic                                       req_valid,
    output l2_wb_pkg::dir_op_t                         req_op,
    output logic [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] req_tag,
    output logic [$clog2(SETS)-1:0]                    req_set,
    output l2_dir_pkg::line_state_t                    req_state
);

    localparam int IDX_BITS = $clog2(SETS);

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } dec_state_t;

    dec_state_t state;
    logic       start;
    logic [1:0] op_bits;

    assign start   = (state == DEC_IDLE) && wb_cyc && wb_stb;
    assign op_bits = wb_dat_i[l2_wb_pkg::REQ_OP_LSB +: 2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= DEC_IDLE;
            req_valid <= 1'b0;
        end else begin
            req_valid <= start;                     // One pulse per accepted request
            case (state)
                DEC_IDLE: if (start) state <= DEC_BUSY;
                DEC_BUSY: if (done) state <= DEC_IDLE;
                default:  state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_set <= wb_adr[IDX_BITS-1:0];
            req_tag <= wb_adr[l2_dir_pkg::LINE_ADDR_BITS-1:IDX_BITS];
            if (wb_we) begin
                // An unknown opcode is served as a plain lookup
                if (op_bits == l2_wb_pkg::OP_FILL)
                    req_op <= l2_wb_pkg::OP_FILL;
                else if (op_bits == l2_wb_pkg::OP_INVAL)
                    req_op <= l2_wb_pkg::OP_INVAL;
                else
                    req_op <= l2_wb_pkg::OP_LOOKUP;
                req_state <= l2_dir_pkg::line_state_t'(wb_dat_i[l2_wb_pkg::REQ_STATE_LSB +: 2]);
            end else begin
                req_op    <= l2_wb_pkg::OP_LOOKUP;
                req_state <= l2_dir_pkg::ST_INVALID;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_tag_array.sv
`default_nettype none

module l2_tag_array #(
    parameter int WAYS = l2_dir_pkg::DEF_WAYS,
    parameter int SETS = l2_dir_pkg::DEF_SETS
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 rd_en,
    input  wire [$clog2(SETS)-1:0]              rd_set,
    input  wire l2_wb_pkg::dir_op_t             in_op,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] in_tag,
    input  wire l2_dir_pkg::line_state_t        in_state,
    input  wire                                 wr_en,
    input  wire [$clog2(SETS)-1:0]              wr_set,
    input  wire [$clog2(WAYS)-1:0]              wr_way,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] wr_tag,
    input  wire l2_dir_pkg::line_state_t        wr_state,
    output logic [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] tags_out [WAYS],
    output l2_dir_pkg::line_state_t             states_out [WAYS],
    output logic                                rd_valid,
    output l2_wb_pkg::dir_op_t                  out_op,
    output logic [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] out_tag,
    output logic [$clog2(SETS)-1:0]             out_set,
    output l2_dir_pkg::line_state_t             out_state
);

    localparam int TAG_BITS = l2_dir_pkg::LINE_ADDR_BITS - $clog2(SETS);

    logic [TAG_BITS-1:0]     tag_mem   [SETS][WAYS];
    l2_dir_pkg::line_state_t state_mem [SETS][WAYS];

    // States must start invalid so every way reads as empty after reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++)
                for (int w = 0; w < WAYS; w++)
                    state_mem[s][w] <= l2_dir_pkg::ST_INVALID;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (wr_en)
                state_mem[wr_set][wr_way] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            tag_mem[wr_set][wr_way] <= wr_tag;
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                tags_out[w]   <= tag_mem[rd_set][w];
                states_out[w] <= state_mem[rd_set][w];
            end
        end
        out_op    <= in_op;                         // Request fields ride along with the read
        out_tag   <= in_tag;
        out_set   <= rd_set;
        out_state <= in_state;
    end

endmodule

`default_nettype wire

//--- verilog/l2_lookup.sv
`default_nettype none

module l2_lookup #(
    parameter int WAYS = l2_dir_pkg::DEF_WAYS,
    parameter int SETS = l2_dir_pkg::DEF_SETS
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 lookup_en,
    input  wire l2_wb_pkg::dir_op_t             lookup_mode,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] tags_buf [WAYS],
    input  wire l2_dir_pkg::line_state_t        states_buf [WAYS],
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] in_tag,
    input  wire [$clog2(SETS)-1:0]              in_set,
    input  wire l2_wb_pkg::dir_op_t             in_op,
    input  wire l2_dir_pkg::line_state_t        in_state,
    output logic                                tag_hit,
    output logic [$clog2(WAYS)-1:0]             way_hit,
    output l2_dir_pkg::line_state_t             hit_state,
    output logic                                empty_way_found,
    output logic [$clog2(WAYS)-1:0]             empty_way,
    output logic                                lk_valid,
    output logic [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] out_tag,
    output logic [$clog2(SETS)-1:0]             out_set,
    output l2_wb_pkg::dir_op_t                  out_op,
    output l2_dir_pkg::line_state_t             out_state
);

    localparam int WAY_BITS = $clog2(WAYS);

    logic                    tag_hit_next, empty_found_next;
    logic [WAY_BITS-1:0]     way_hit_next, empty_way_next;
    l2_dir_pkg::line_state_t hit_state_next;

    // Walk from the top way down so the lowest match is the one that sticks
    always_comb begin
        tag_hit_next     = 1'b0;
        way_hit_next     = '0;
        hit_state_next   = l2_dir_pkg::ST_INVALID;
        empty_found_next = 1'b0;
        empty_way_next   = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (tags_buf[i] == in_tag && states_buf[i] != l2_dir_pkg::ST_INVALID) begin
                tag_hit_next   = 1'b1;
                way_hit_next   = WAY_BITS'(i);
                hit_state_next = states_buf[i];
            end
            if (lookup_mode != l2_wb_pkg::OP_INVAL && states_buf[i] == l2_dir_pkg::ST_INVALID) begin
                empty_found_next = 1'b1;            // Invalidates skip the empty search
                empty_way_next   = WAY_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_hit         <= 1'b0;
            way_hit         <= '0;
            hit_state       <= l2_dir_pkg::ST_INVALID;
            empty_way_found <= 1'b0;
            empty_way       <= '0;
            lk_valid        <= 1'b0;
        end else begin
            lk_valid <= lookup_en;
            if (lookup_en) begin
                tag_hit         <= tag_hit_next;
                way_hit         <= way_hit_next;
                hit_state       <= hit_state_next;
                empty_way_found <= empty_found_next;
                empty_way       <= empty_way_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            out_tag   <= in_tag;
            out_set   <= in_set;
            out_op    <= in_op;
            out_state <= in_state;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_update.sv
`default_nettype none

module l2_update #(
    parameter int WAYS = l2_dir_pkg::DEF_WAYS,
    parameter int SETS = l2_dir_pkg::DEF_SETS
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 tag_hit,
    input  wire [$clog2(WAYS)-1:0]              way_hit,
    input  wire l2_dir_pkg::line_state_t        hit_state,
    input  wire                                 empty_way_found,
    input  wire [$clog2(WAYS)-1:0]              empty_way,
    input  wire                                 lk_valid,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] in_tag,
    input  wire [$clog2(SETS)-1:0]              in_set,
    input  wire l2_wb_pkg::dir_op_t             in_op,
    input  wire l2_dir_pkg::line_state_t        in_state,
    output logic                                wr_en,
    output logic [$clog2(SETS)-1:0]             wr_set,
    output logic [$clog2(WAYS)-1:0]             wr_way,
    output logic [l2_dir_pkg::LINE_ADDR_BITS-$clog2(SETS)-1:0] wr_tag,
    output l2_dir_pkg::line_state_t             wr_state,
    output logic                                wb_ack,
    output logic [l2_wb_pkg::WB_DATA_BITS-1:0]  wb_dat_o,
    output logic                                done
);

    localparam int WAY_BITS = $clog2(WAYS);

    logic [WAY_BITS-1:0]              victim [SETS];    // Round-robin pointer per set
    logic                             use_victim;
    logic [WAY_BITS-1:0]              victim_next;
    logic [l2_wb_pkg::WB_DATA_BITS-1:0] rsp_word;

    // ============================================================
    // Way selection
    // ============================================================

    always_comb begin
        wr_en      = 1'b0;
        wr_way     = '0;
        use_victim = 1'b0;
        if (lk_valid) begin
            case (in_op)
                l2_wb_pkg::OP_FILL: begin
                    wr_en = 1'b1;
                    if (tag_hit) begin
                        wr_way = way_hit;           // Line present, only its state changes
                    end else if (empty_way_found) begin
                        wr_way = empty_way;
                    end else begin
                        wr_way     = victim[in_set];
                        use_victim = 1'b1;
                    end
                end
                l2_wb_pkg::OP_INVAL: begin
                    wr_en  = tag_hit;
                    wr_way = way_hit;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    assign wr_set      = in_set;
    assign wr_tag      = in_tag;
    assign wr_state    = (in_op == l2_wb_pkg::OP_INVAL) ? l2_dir_pkg::ST_INVALID : in_state;
    assign victim_next = (victim[in_set] == WAY_BITS'(WAYS - 1)) ? '0 : victim[in_set] + 1'b1;

    // ============================================================
    // Response
    // ============================================================

    always_comb begin
        rsp_word = '0;
        rsp_word[l2_wb_pkg::RSP_HIT_BIT]          = tag_hit;
        rsp_word[l2_wb_pkg::RSP_EMPTY_BIT]        = empty_way_found;
        rsp_word[l2_wb_pkg::RSP_WAY_LSB +: 2]     = tag_hit ? 2'(way_hit) : 2'(empty_way);
        rsp_word[l2_wb_pkg::RSP_STATE_LSB +: 2]   = hit_state;
        rsp_word[l2_wb_pkg::RSP_WR_WAY_LSB +: 2]  = wr_en ? 2'(wr_way) : 2'b00;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_ack   <= 1'b0;
            done     <= 1'b0;
            wb_dat_o <= '0;
            for (int s = 0; s < SETS; s++)
                victim[s] <= '0;
        end else begin
            wb_ack <= lk_valid;                     // Array write and ack land on the same edge
            done   <= lk_valid;
            if (lk_valid)
                wb_dat_o <= rsp_word;
            if (use_victim)
                victim[in_set] <= victim_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_dir_top.sv
`default_nettype none

module l2_dir_top #(
    parameter int WAYS = l2_dir_pkg::DEF_WAYS,
    parameter int SETS = l2_dir_pkg::DEF_SETS
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    wb_cyc,
    input  wire                                    wb_stb,
    input  wire                                    wb_we,
    input  wire [l2_dir_pkg::LINE_ADDR_BITS-1:0]   wb_adr,
    input  wire [l2_wb_pkg::WB_DATA_BITS-1:0]      wb_dat_i,
    output logic [l2_wb_pkg::WB_DATA_BITS-1:0]     wb_dat_o,
    output logic                                   wb_ack
);

    localparam int IDX_BITS = $clog2(SETS);
    localparam int TAG_BITS = l2_dir_pkg::LINE_ADDR_BITS - IDX_BITS;
    localparam int WAY_BITS = $clog2(WAYS);

    // Decode to array
    logic                    req_valid, done;
    l2_wb_pkg::dir_op_t      req_op;
    logic [TAG_BITS-1:0]     req_tag;
    logic [IDX_BITS-1:0]     req_set;
    l2_dir_pkg::line_state_t req_state;

    // Array to compare
    logic [TAG_BITS-1:0]     tags_out [WAYS];
    l2_dir_pkg::line_state_t states_out [WAYS];
    logic                    rd_valid;
    l2_wb_pkg::dir_op_t      ta_op;
    logic [TAG_BITS-1:0]     ta_tag;
    logic [IDX_BITS-1:0]     ta_set;
    l2_dir_pkg::line_state_t ta_state;

    // Compare to update
    logic                    tag_hit, empty_way_found, lk_valid;
    logic [WAY_BITS-1:0]     way_hit, empty_way;
    l2_dir_pkg::line_state_t hit_state;
    l2_wb_pkg::dir_op_t      lk_op;
    logic [TAG_BITS-1:0]     lk_tag;
    logic [IDX_BITS-1:0]     lk_set;
    l2_dir_pkg::line_state_t lk_state;

    // Update back to the array
    logic                    wr_en;
    logic [IDX_BITS-1:0]     wr_set;
    logic [WAY_BITS-1:0]     wr_way;
    logic [TAG_BITS-1:0]     wr_tag;
    l2_dir_pkg::line_state_t wr_state;

    l2_req_decode #(.SETS(SETS)) u_decode (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .done(done), .req_valid(req_valid),
        .req_op(req_op), .req_tag(req_tag), .req_set(req_set), .req_state(req_state)
    );

    l2_tag_array #(.WAYS(WAYS), .SETS(SETS)) u_tag_array (
        .clk(clk), .rst(rst), .rd_en(req_valid), .rd_set(req_set), .in_op(req_op),
        .in_tag(req_tag), .in_state(req_state), .wr_en(wr_en), .wr_set(wr_set),
        .wr_way(wr_way), .wr_tag(wr_tag), .wr_state(wr_state), .tags_out(tags_out),
        .states_out(states_out), .rd_valid(rd_valid), .out_op(ta_op), .out_tag(ta_tag),
        .out_set(ta_set), .out_state(ta_state)
    );

    l2_lookup #(.WAYS(WAYS), .SETS(SETS)) u_lookup (
        .clk(clk), .rst(rst), .lookup_en(rd_valid), .lookup_mode(ta_op),
        .tags_buf(tags_out), .states_buf(states_out), .in_tag(ta_tag), .in_set(ta_set),
        .in_op(ta_op), .in_state(ta_state), .tag_hit(tag_hit), .way_hit(way_hit),
        .hit_state(hit_state), .empty_way_found(empty_way_found), .empty_way(empty_way),
        .lk_valid(lk_valid), .out_tag(lk_tag), .out_set(lk_set), .out_op(lk_op),
        .out_state(lk_state)
    );

    l2_update #(.WAYS(WAYS), .SETS(SETS)) u_update (
        .clk(clk), .rst(rst), .tag_hit(tag_hit), .way_hit(way_hit), .hit_state(hit_state),
        .empty_way_found(empty_way_found), .empty_way(empty_way), .lk_valid(lk_valid),
        .in_tag(lk_tag), .in_set(lk_set), .in_op(lk_op), .in_state(lk_state),
        .wr_en(wr_en), .wr_set(wr_set), .wr_way(wr_way), .wr_tag(wr_tag),
        .wr_state(wr_state), .wb_ack(wb_ack), .wb_dat_o(wb_dat_o), .done(done)
    );

endmodule

`default_nettype wire

//--- dv/l2_dir_tb.sv
`default_nettype none

module l2_dir_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAYS         = l2_dir_pkg::DEF_WAYS;
    localparam int SETS         = l2_dir_pkg::DEF_SETS;
    localparam int IDX_BITS     = $clog2(SETS);
    localparam int TAG_BITS     = l2_dir_pkg::LINE_ADDR_BITS - IDX_BITS;
    localparam int RSP_BITS     = l2_wb_pkg::WB_DATA_BITS;
    localparam int CLK_PERIOD   = 40;
    localparam int ACK_LIMIT    = 8;
    localparam int DIRECTED_OPS = 31;
    localparam int RANDOM_OPS   = 200;
    localparam int TIMEOUT_NS   = ((DIRECTED_OPS + RANDOM_OPS) * 8 + 20) * CLK_PERIOD;

    logic                 clk, rst, wb_cyc, wb_stb, wb_we, wb_ack, strobe;
    logic [l2_dir_pkg::LINE_ADDR_BITS-1:0] wb_adr;
    logic [RSP_BITS-1:0]  wb_dat_i, wb_dat_o, expected_rsp;
    int                   error_count, op_count, ack_count;

    // Reference directory
    logic [TAG_BITS-1:0]     model_tag    [SETS][WAYS];
    l2_dir_pkg::line_state_t model_state  [SETS][WAYS];
    int                      model_victim [SETS];

    l2_dir_top #(.WAYS(WAYS), .SETS(SETS)) DUT (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    assign strobe = wb_cyc && wb_stb;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the run timed out after %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ============================================================
    // Reference model
    // ============================================================

    function automatic logic [RSP_BITS-1:0] model_apply(input l2_wb_pkg::dir_op_t op,
                                                        input logic [TAG_BITS-1:0] tag,
                                                        input logic [IDX_BITS-1:0] set_idx,
                                                        input l2_dir_pkg::line_state_t st);
        logic                    hit, empty, wrote;
        int                      hit_way, empty_way, wr_way;
        l2_dir_pkg::line_state_t hit_st;
        logic [RSP_BITS-1:0]     rsp;
        hit       = 1'b0;
        empty     = 1'b0;
        wrote     = 1'b0;
        hit_way   = 0;
        empty_way = 0;
        wr_way    = 0;
        hit_st    = l2_dir_pkg::ST_INVALID;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && model_state[set_idx][w] != l2_dir_pkg::ST_INVALID &&
                model_tag[set_idx][w] == tag) begin
                hit     = 1'b1;
                hit_way = w;
                hit_st  = model_state[set_idx][w];
            end
            if (!empty && op != l2_wb_pkg::OP_INVAL &&
                model_state[set_idx][w] == l2_dir_pkg::ST_INVALID) begin
                empty     = 1'b1;
                empty_way = w;
            end
        end
        if (op == l2_wb_pkg::OP_FILL) begin
            wrote = 1'b1;
            if (hit) begin
                wr_way = hit_way;
            end else if (empty) begin
                wr_way = empty_way;
            end else begin
                wr_way = model_victim[set_idx];       // A full set evicts the victim way
                model_victim[set_idx] = (model_victim[set_idx] + 1) % WAYS;
            end
            model_tag[set_idx][wr_way]   = tag;
            model_state[set_idx][wr_way] = st;
        end else if (op == l2_wb_pkg::OP_INVAL && hit) begin
            wrote  = 1'b1;
            wr_way = hit_way;
            model_state[set_idx][hit_way] = l2_dir_pkg::ST_INVALID;
        end
        rsp = '0;
        rsp[l2_wb_pkg::RSP_HIT_BIT]          = hit;
        rsp[l2_wb_pkg::RSP_EMPTY_BIT]        = empty;
        rsp[l2_wb_pkg::RSP_WAY_LSB +: 2]     = hit ? 2'(hit_way) : 2'(empty_way);
        rsp[l2_wb_pkg::RSP_STATE_LSB +: 2]   = hit_st;
        rsp[l2_wb_pkg::RSP_WR_WAY_LSB +: 2]  = wrote ? 2'(wr_way) : 2'b00;
        return rsp;
    endfunction

    // ============================================================
    // Bus tasks
    // ============================================================

    task automatic run_cycle(input logic we, input l2_wb_pkg::dir_op_t op,
                             input logic [TAG_BITS-1:0] tag,
                             input logic [IDX_BITS-1:0] set_idx,
                             input l2_dir_pkg::line_state_t st);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        expected_rsp = model_apply(op, tag, set_idx, st);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = {tag, set_idx};
        wb_dat_i = '0;
        if (we) begin
            wb_dat_i[l2_wb_pkg::REQ_OP_LSB +: 2]    = op;
            wb_dat_i[l2_wb_pkg::REQ_STATE_LSB +: 2] = st;
        end
        op_count++;
        @(negedge clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            error_count++;
            $display("No acknowledge within %0d cycles for tag %h in set %0d",
                     ACK_LIMIT, tag, set_idx);
        end
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;                                // Master idles one cycle between requests
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [TAG_BITS-1:0] tag, input logic [IDX_BITS-1:0] set_idx);
        run_cycle(1'b0, l2_wb_pkg::OP_LOOKUP, tag, set_idx, l2_dir_pkg::ST_INVALID);
    endtask

    task automatic wb_write(input l2_wb_pkg::dir_op_t op, input logic [TAG_BITS-1:0] tag,
                            input logic [IDX_BITS-1:0] set_idx,
                            input l2_dir_pkg::line_state_t st);
        run_cycle(1'b1, op, tag, set_idx, st);
    endtask

    // ============================================================
    // Response checks
    // ============================================================

    // A strobe first seen at one negedge is taken on the next rising edge, and the ack
    // registered three edges later is seen four negedges after the strobe appeared
    ack_latency: assert property (@(negedge clk) disable iff (!rst)
            wb_ack |-> $past(strobe, 4) && !$past(strobe, 5))
        else begin
            error_count++;
            $display("[ERROR] %0d ns: acknowledge not 3 cycles after the strobe", $time);
        end

    ack_single: assert property (@(negedge clk) disable iff (!rst) wb_ack |-> !$past(wb_ack))
        else begin
            error_count++;
            $display("[ERROR] %0d ns: acknowledge longer than one cycle", $time);
        end

    rsp_match: assert property (@(negedge clk) disable iff (!rst)
            wb_ack |-> wb_dat_o == expected_rsp)
        else begin
            error_count++;
            $display("[ERROR] %0d ns: response %h, expected %h", $time, wb_dat_o, expected_rsp);
        end

    always @(negedge clk) begin
        if (rst && wb_ack)
            ack_count++;
    end

    initial begin
        logic [TAG_BITS-1:0]     tag;
        logic [IDX_BITS-1:0]     set_idx;
        l2_dir_pkg::line_state_t st;
        int                      pick;
        void'($urandom(64));
        rst         = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_i    = '0;
        error_count = 0;
        op_count    = 0;
        ack_count   = 0;
        for (int s = 0; s < SETS; s++) begin
            model_victim[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                model_tag[s][w]   = '0;
                model_state[s][w] = l2_dir_pkg::ST_INVALID;
            end
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        reset_idle: assert (!wb_ack) else begin
            error_count++;
            $display("[ERROR] %0d ns: acknowledge high after reset", $time);
        end

        wb_read(12'h001, 4'd0);                      // Empty directory misses everywhere
        wb_read(12'h002, 4'd5);
        wb_read(12'h003, 4'd15);

        wb_write(l2_wb_pkg::OP_FILL, 12'h0A1, 4'd3, l2_dir_pkg::ST_SHARED);
        wb_read(12'h0A1, 4'd3);
        wb_write(l2_wb_pkg::OP_FILL, 12'h0A1, 4'd3, l2_dir_pkg::ST_MODIFIED);
        wb_read(12'h0A1, 4'd3);

        for (int i = 0; i < 6; i++)                  // Last two fills evict ways 0 and 1
            wb_write(l2_wb_pkg::OP_FILL, TAG_BITS'(16 + i), 4'd7, l2_dir_pkg::ST_EXCLUSIVE);
        wb_read(12'h010, 4'd7);

        // The state bits of an invalidate are ignored and the way still ends up invalid
        wb_write(l2_wb_pkg::OP_INVAL, 12'h012, 4'd7, l2_dir_pkg::ST_MODIFIED);
        wb_read(12'h012, 4'd7);
        wb_write(l2_wb_pkg::OP_INVAL, 12'h099, 4'd7, l2_dir_pkg::ST_INVALID);

        // Separate sets keep separate victim pointers
        for (int i = 0; i < 5; i++)
            wb_write(l2_wb_pkg::OP_FILL, TAG_BITS'(256 + i), 4'd9, l2_dir_pkg::ST_SHARED);
        for (int i = 0; i < 5; i++)
            wb_write(l2_wb_pkg::OP_FILL, TAG_BITS'(512 + i), 4'd10, l2_dir_pkg::ST_SHARED);
        wb_write(l2_wb_pkg::OP_FILL, 12'h105, 4'd9, l2_dir_pkg::ST_EXCLUSIVE);
        wb_read(12'h100, 4'd9);
        wb_read(12'h200, 4'd10);
        wb_read(12'h201, 4'd10);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick    = int'($urandom % 3);
            tag     = TAG_BITS'(12'h300 + ($urandom % 6));
            set_idx = IDX_BITS'($urandom % 4);
            st      = l2_dir_pkg::line_state_t'(($urandom % 3) + 1);
            case (pick)
                0:       wb_read(tag, set_idx);
                1:       wb_write(l2_wb_pkg::OP_FILL, tag, set_idx, st);
                default: wb_write(l2_wb_pkg::OP_INVAL, tag, set_idx, st);
            endcase
        end

        repeat (4) @(posedge clk);
        if (ack_count != op_count) begin
            error_count++;
            $display("Acknowledge count does not match the number of operations");
        end
        $display("Operations %0d, acknowledges %0d, errors %0d", op_count, ack_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/l2_dir_pkg.sv
verilog/l2_wb_pkg.sv
verilog/l2_req_decode.sv
verilog/l2_tag_array.sv
verilog/l2_lookup.sv
verilog/l2_update.sv
verilog/l2_dir_top.sv
dv/l2_dir_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module l2_dir_tb -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vl2_dir_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
